// ==== build.f ====
+incdir+design
design/event_unit_pkg.sv
design/event_ctrl_if.sv
design/event_wb_slave.sv
design/cluster_event_map.sv
design/event_barrier.sv
design/event_core_buffers.sv
design/cluster_event_unit.sv
tests/tb_cluster_event_unit.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f build.f --top-module tb_cluster_event_unit \
  > sim.log 2>&1 \
  && ./obj_dir/Vtb_cluster_event_unit >> sim.log 2>&1 \
  || echo "Simulation failed" >> sim.log

cat sim.log

if grep -q "Simulation failed" sim.log; then
  exit 1
fi
exit 0

// ==== tests/tb_cluster_event_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "event_unit_macros.svh"

module tb_cluster_event_unit;
  import event_unit_pkg::*;

  localparam int ack_timeout = 20;

  logic                           clk_i;
  logic                           reset_i;
  logic                           wb_cyc;
  logic                           wb_stb;
  logic                           wb_we;
  wb_addr_t                       wb_adr;
  wb_data_t                       wb_wdat;
  wb_data_t                       wb_rdat;
  logic                           wb_ack;
  logic [`EU_NB_CORES-1:0][3:0]   acc_events;
  logic [`EU_NB_CORES-1:0][1:0]   dma_events;
  logic [`EU_NB_CORES-1:0][1:0]   timer_events;
  logic [`EU_NB_CORES-1:0][1:0]   cluster_events;
  logic                           mailbox_evt;
  logic                           fifo_evt;
  core_mask_t                     core_evt;

  // reference model of what each buffer and mask should hold
  evt_line_t  exp_buf  [`EU_NB_CORES];
  evt_line_t  exp_mask [`EU_NB_CORES];
  int         error_count;
  int         test_count;
  int         failed_tests;
  int         last_ack_cycles;
  core_mask_t evt_at_ack;
  logic       timed_out;

  cluster_event_unit i_dut (
    .clk_i               (clk_i),
    .reset_i             (reset_i),
    .wb_cyc_i            (wb_cyc),
    .wb_stb_i            (wb_stb),
    .wb_we_i             (wb_we),
    .wb_adr_i            (wb_adr),
    .wb_dat_i            (wb_wdat),
    .wb_dat_o            (wb_rdat),
    .wb_ack_o            (wb_ack),
    .acc_events_i        (acc_events),
    .dma_events_i        (dma_events),
    .timer_events_i      (timer_events),
    .cluster_events_i    (cluster_events),
    .mailbox_evt_i       (mailbox_evt),
    .periph_fifo_event_i (fifo_evt),
    .core_evt_o          (core_evt)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // a missing ack ends the run from here
  initial begin
    wait (timed_out);
    $display("Simulation failed");
    $finish;
  end

  // byte address of a per-core register
  function automatic wb_addr_t reg_addr(input int core, input wb_addr_t off);
    reg_addr = {core[3:0], 4'h0} | off;
  endfunction

  // event line of one core as the bit map places each source
  function automatic evt_line_t map_line(input logic [7:0] sw, input logic bar,
                                         input logic [3:0] acc, input logic [1:0] dma,
                                         input logic [1:0] timer, input logic [1:0] clus,
                                         input logic mb, input logic fifo);
    evt_line_t line;
    line        = '0;
    line[7:0]   = sw;
    line[9:8]   = dma;
    line[11:10] = timer;
    line[15:12] = acc;
    line[16]    = bar;
    line[23:22] = clus;
    line[24]    = mb;
    line[27]    = fifo;
    return line;
  endfunction

  // a core wants to wake when any buffered bit is also enabled
  function automatic core_mask_t expected_wake();
    core_mask_t w;
    for (int c = 0; c < `EU_NB_CORES; c++) begin
      w[c] = |(exp_buf[c] & exp_mask[c]);
    end
    return w;
  endfunction

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("ERROR @%0t ns: %s is %h, expected %h", $time, what, got, exp);
      error_count++;
    end
  endtask

  // counts falling edges until the ack shows up, the ack edge included
  task automatic wait_ack();
    logic got_ack;
    got_ack         = 1'b0;
    last_ack_cycles = 0;
    while (!got_ack && last_ack_cycles < ack_timeout) begin
      @(negedge clk_i);
      last_ack_cycles++;
      got_ack = wb_ack;
    end
    evt_at_ack = core_evt;
    if (!got_ack) begin
      $display("timeout: no wishbone ack within %0d cycles at %0t ns", ack_timeout, $time);
      timed_out = 1'b1;
    end
  endtask

  // every transfer ends with one idle cycle so the next one starts clean
  task automatic wb_write(input wb_addr_t addr, input wb_data_t data);
    wb_cyc  = 1'b1;
    wb_stb  = 1'b1;
    wb_we   = 1'b1;
    wb_adr  = addr;
    wb_wdat = data;
    wait_ack();
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    @(negedge clk_i);
  endtask

  task automatic wb_read(input wb_addr_t addr, output wb_data_t data);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = 1'b0;
    wb_adr = addr;
    wait_ack();
    data   = wb_rdat;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    @(negedge clk_i);
  endtask

  task automatic clear_buffers();
    for (int c = 0; c < `EU_NB_CORES; c++) begin
      wb_write(reg_addr(c, `EU_REG_CLEAR), 32'hFFFF_FFFF);
      exp_buf[c] = '0;
    end
  endtask

  task automatic write_masks(input evt_line_t m);
    for (int c = 0; c < `EU_NB_CORES; c++) begin
      wb_write(reg_addr(c, `EU_REG_MASK), m);
      exp_mask[c] = m;
    end
  endtask

  task automatic check_buffers();
    wb_data_t rd;
    for (int c = 0; c < `EU_NB_CORES; c++) begin
      wb_read(reg_addr(c, `EU_REG_BUFFER), rd);
      check_value($sformatf("BUFFER of core %0d", c), rd, exp_buf[c]);
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    test_count++;
    if (error_count == errs_before) begin
      $display("test %s: passed", name);
    end else begin
      failed_tests++;
      $display("test %s: %0d errors", name, error_count - errs_before);
    end
  endtask

  task automatic reset_defaults();
    int       errs;
    wb_data_t rd;
    errs = error_count;
    check_value("core_evt_o after reset", 32'(core_evt), 32'h0);
    for (int c = 0; c < `EU_NB_CORES; c++) begin
      wb_read(reg_addr(c, `EU_REG_MASK), rd);
      check_value($sformatf("MASK of core %0d", c), rd, 32'h0);
      // each read after reset also checks the ack latency
      check_value("ack latency in cycles", last_ack_cycles, 32'd1);
    end
    check_buffers();
    wb_read(`EU_REG_BAR_TARGET, rd);
    check_value("BAR_TARGET", rd, 32'h0);
    report_test("reset_defaults", errs);
  endtask

  task automatic map_buffering();
    int          errs;
    logic [31:0] rnd;
    errs = error_count;
    // one cycle of random per-core events plus both broadcast sources
    for (int c = 0; c < `EU_NB_CORES; c++) begin
      rnd               = $urandom;
      acc_events[c]     = rnd[3:0];
      dma_events[c]     = rnd[5:4];
      timer_events[c]   = rnd[7:6];
      cluster_events[c] = rnd[9:8];
    end
    mailbox_evt = 1'b1;
    fifo_evt    = 1'b1;
    for (int c = 0; c < `EU_NB_CORES; c++) begin
      exp_buf[c] |= map_line(8'h00, 1'b0, acc_events[c], dma_events[c], timer_events[c],
                             cluster_events[c], 1'b1, 1'b1);
    end
    @(negedge clk_i);
    acc_events     = '0;
    dma_events     = '0;
    timer_events   = '0;
    cluster_events = '0;
    mailbox_evt    = 1'b0;
    fifo_evt       = 1'b0;
    check_buffers();
    // the bits are sticky and must still be there later
    repeat (5) @(negedge clk_i);
    check_buffers();
    report_test("map_buffering", errs);
  endtask

  task automatic mask_and_wake();
    int        errs;
    wb_data_t  rd;
    evt_line_t clr;
    errs = error_count;
    for (int c = 0; c < `EU_NB_CORES; c++) begin
      exp_mask[c] = $urandom;
      wb_write(reg_addr(c, `EU_REG_MASK), exp_mask[c]);
      wb_read(reg_addr(c, `EU_REG_MASK), rd);
      check_value($sformatf("MASK of core %0d", c), rd, exp_mask[c]);
      wb_read(reg_addr(c, `EU_REG_MASKED), rd);
      check_value($sformatf("MASKED of core %0d", c), rd, exp_buf[c] & exp_mask[c]);
    end
    check_value("core_evt_o with random masks", 32'(core_evt), 32'(expected_wake()));
    // random bits are cleared, the rest of each buffer has to survive
    for (int c = 0; c < `EU_NB_CORES; c++) begin
      clr = $urandom;
      wb_write(reg_addr(c, `EU_REG_CLEAR), clr);
      exp_buf[c] &= ~clr;
    end
    check_buffers();
    check_value("core_evt_o after clear", 32'(core_evt), 32'(expected_wake()));
    report_test("mask_and_wake", errs);
  endtask

  task automatic software_events();
    int          errs;
    logic [31:0] rnd;
    logic [7:0]  sw;
    core_mask_t  tgt;
    errs = error_count;
    clear_buffers();
    write_masks(32'h0000_00FF);
    rnd = $urandom;
    sw  = rnd[7:0] | 8'h01;
    tgt = rnd[11:8];
    if (tgt == '0) begin
      tgt = 4'b0101;
    end
    wb_write(`EU_REG_SW_TRIG, {20'h0, tgt, sw});
    // nothing is buffered at the ack, the targets wake one cycle later
    check_value("core_evt_o at SW_TRIG ack", 32'(evt_at_ack), 32'h0);
    check_value("core_evt_o after SW_TRIG ack", 32'(core_evt), 32'(tgt));
    for (int c = 0; c < `EU_NB_CORES; c++) begin
      exp_buf[c] = tgt[c] ? map_line(sw, 1'b0, 4'h0, 2'b00, 2'b00, 2'b00, 1'b0, 1'b0) : '0;
    end
    check_buffers();
    report_test("software_events", errs);
  endtask

  task automatic barrier_rounds();
    int          errs;
    int          order [$];
    int          swap_idx;
    int          tmp;
    logic [31:0] rnd;
    core_mask_t  tgt;
    errs = error_count;
    write_masks(32'h0001_0000);
    for (int round = 0; round < 2; round++) begin
      clear_buffers();
      // three of the four cores take part, in a random order
      rnd = $urandom;
      tgt = ~(core_mask_t'(1) << rnd[1:0]);
      order.delete();
      for (int c = 0; c < `EU_NB_CORES; c++) begin
        if (tgt[c]) begin
          order.push_back(c);
        end
      end
      // random picks for the first two arrivals reach any of the six orders
      swap_idx        = int'(rnd[3:2]) % 3;
      tmp             = order[0];
      order[0]        = order[swap_idx];
      order[swap_idx] = tmp;
      swap_idx        = 1 + int'(rnd[4]);
      tmp             = order[1];
      order[1]        = order[swap_idx];
      order[swap_idx] = tmp;
      wb_write(`EU_REG_BAR_TARGET, 32'(tgt));
      for (int k = 0; k < 2; k++) begin
        wb_write(`EU_REG_BAR_ARRIVE, 32'(1) << order[k]);
        repeat (3) @(negedge clk_i);
        check_value($sformatf("core_evt_o after %0d arrivals", k + 1), 32'(core_evt), 32'h0);
      end
      // the release reaches the buffers two cycles after the last ack
      wb_write(`EU_REG_BAR_ARRIVE, 32'(1) << order[2]);
      check_value("core_evt_o at last arrive ack", 32'(evt_at_ack), 32'h0);
      check_value("core_evt_o one cycle after ack", 32'(core_evt), 32'h0);
      @(negedge clk_i);
      check_value($sformatf("core_evt_o after release in round %0d", round),
                  32'(core_evt), 32'(tgt));
      for (int c = 0; c < `EU_NB_CORES; c++) begin
        exp_buf[c] = tgt[c] ? 32'h0001_0000 : 32'h0;
      end
      check_buffers();
    end
    report_test("barrier_rounds", errs);
  endtask

  task automatic set_beats_clear();
    int          errs;
    int          core;
    logic [31:0] rnd;
    wb_data_t    rd;
    errs = error_count;
    clear_buffers();
    rnd  = $urandom;
    core = int'(rnd[1:0]);
    // the timer event stays high across the whole clear transfer
    timer_events[core] = 2'b01;
    wb_write(reg_addr(core, `EU_REG_CLEAR), 32'h0000_0400);
    timer_events[core] = 2'b00;
    @(negedge clk_i);
    wb_read(reg_addr(core, `EU_REG_BUFFER), rd);
    check_value("BUFFER after clear during event", rd, 32'h0000_0400);
    // once the event is gone the same clear removes the bit
    wb_write(reg_addr(core, `EU_REG_CLEAR), 32'h0000_0400);
    wb_read(reg_addr(core, `EU_REG_BUFFER), rd);
    check_value("BUFFER after plain clear", rd, 32'h0);
    exp_buf[core] = '0;
    report_test("set_beats_clear", errs);
  endtask

  initial begin
    void'($urandom(32'h4c04));
    reset_i        = 1'b1;
    wb_cyc         = 1'b0;
    wb_stb         = 1'b0;
    wb_we          = 1'b0;
    wb_adr         = '0;
    wb_wdat        = '0;
    acc_events     = '0;
    dma_events     = '0;
    timer_events   = '0;
    cluster_events = '0;
    mailbox_evt    = 1'b0;
    fifo_evt       = 1'b0;
    error_count    = 0;
    test_count     = 0;
    failed_tests   = 0;
    timed_out      = 1'b0;
    for (int c = 0; c < `EU_NB_CORES; c++) begin
      exp_buf[c]  = '0;
      exp_mask[c] = '0;
    end
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    reset_defaults();
    map_buffering();
    mask_and_wake();
    software_events();
    barrier_rounds();
    set_beats_clear();
    $display("tests run: %0d, tests failed: %0d, errors: %0d",
             test_count, failed_tests, error_count);
    if (error_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== design/cluster_event_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "event_unit_macros.svh"

module cluster_event_unit (
  input  logic                              clk_i,
  input  logic                              reset_i,
  // register bus
  input  logic                              wb_cyc_i,
  input  logic                              wb_stb_i,
  input  logic                              wb_we_i,
  input  event_unit_pkg::wb_addr_t          wb_adr_i,
  input  event_unit_pkg::wb_data_t          wb_dat_i,
  output event_unit_pkg::wb_data_t          wb_dat_o,
  output logic                              wb_ack_o,
  // event sources from the rest of the cluster
  input  logic [`EU_NB_CORES-1:0][3:0]      acc_events_i,
  input  logic [`EU_NB_CORES-1:0][1:0]      dma_events_i,
  input  logic [`EU_NB_CORES-1:0][1:0]      timer_events_i,
  input  logic [`EU_NB_CORES-1:0][1:0]      cluster_events_i,
  input  logic                              mailbox_evt_i,
  input  logic                              periph_fifo_event_i,
  // one wake request per core
  output event_unit_pkg::core_mask_t        core_evt_o
);
  import event_unit_pkg::*;

  // release pulses from the barrier into the map
  core_mask_t                   barrier_events;
  // fully assembled event line of every core
  evt_line_t [`EU_NB_CORES-1:0] events_mapped;

  // register state and strobes shared by slave, barrier and buffers
  event_ctrl_if ctrl_if ();

  // the bus side decodes the registers and produces the strobes
  event_wb_slave u_wb_slave (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_we_i  (wb_we_i),
    .wb_adr_i (wb_adr_i),
    .wb_dat_i (wb_dat_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack_o (wb_ack_o),
    .ctrl_if  (ctrl_if.ctrl)
  );

  // the barrier turns arrive writes into a release pulse
  event_barrier u_barrier (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .ctrl_if          (ctrl_if.evt),
    .barrier_events_o (barrier_events)
  );

  // all sources are placed on each core's line by the fixed bit map
  cluster_event_map u_event_map (
    .sw_events_i         (ctrl_if.sw_evt),
    .barrier_events_i    (barrier_events),
    .acc_events_i        (acc_events_i),
    .dma_events_i        (dma_events_i),
    .timer_events_i      (timer_events_i),
    .cluster_events_i    (cluster_events_i),
    .mailbox_evt_i       (mailbox_evt_i),
    .periph_fifo_event_i (periph_fifo_event_i),
    .events_mapped_o     (events_mapped)
  );

  // the buffers hold the events and raise the wake requests
  event_core_buffers u_core_buffers (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .events_i   (events_mapped),
    .ctrl_if    (ctrl_if.evt),
    .core_evt_o (core_evt_o)
  );

endmodule

`default_nettype wire

// ==== design/event_core_buffers.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "event_unit_macros.svh"

module event_core_buffers (
  input  logic                                         clk_i,
  input  logic                                         reset_i,
  input  event_unit_pkg::evt_line_t [`EU_NB_CORES-1:0] events_i,
  event_ctrl_if.evt                                    ctrl_if,
  output event_unit_pkg::core_mask_t                   core_evt_o
);
  import event_unit_pkg::*;

  // each core keeps its own sticky copy of its event line
  for (genvar c = 0; c < `EU_NB_CORES; c++) begin : gen_core_buf
    evt_line_t buffer_q;
    evt_line_t buffer_next;
    evt_line_t masked;

    // clear first and then set, so a pulse in the same cycle survives the clear
    assign buffer_next = (buffer_q & ~ctrl_if.buf_clear[c]) | events_i[c];

    always_ff @(posedge clk_i) begin
      if (reset_i) begin
        buffer_q <= '0;
      end else begin
        buffer_q <= buffer_next;
      end
    end

    // the slave reads the buffer back through the interface
    assign ctrl_if.evt_buffer[c] = buffer_q;

    // the core wakes while any buffered event is also enabled in its mask
    assign masked        = buffer_q & ctrl_if.evt_mask[c];
    assign core_evt_o[c] = |masked;
  end

endmodule

`default_nettype wire

// ==== design/event_barrier.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "event_unit_macros.svh"

module event_barrier (
  input  logic                       clk_i,
  input  logic                       reset_i,
  event_ctrl_if.evt                  ctrl_if,
  output event_unit_pkg::core_mask_t barrier_events_o
);
  import event_unit_pkg::*;

  barrier_state_e state_q;
  core_mask_t     arrived_q;
  core_mask_t     arrived_next;
  core_mask_t     target_arrive;
  logic           round_done;

  // arrivals from cores outside the target are dropped
  assign target_arrive = ctrl_if.bar_arrive & ctrl_if.bar_target;
  assign arrived_next  = arrived_q | target_arrive;

  // an empty target never completes, so a cleared barrier stays idle
  assign round_done = (ctrl_if.bar_target != '0) &&
                      ((arrived_next & ctrl_if.bar_target) == ctrl_if.bar_target);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q   <= BAR_COLLECT;
      arrived_q <= '0;
    end else begin
      case (state_q)
        BAR_COLLECT: begin
          arrived_q <= arrived_next;
          // the completing arrive moves us on at this edge
          if (round_done) begin
            state_q <= BAR_RELEASE;
          end
        end
        BAR_RELEASE: begin
          // the new round starts empty except for cores that arrive right now
          arrived_q <= target_arrive;
          state_q   <= BAR_COLLECT;
        end
        default: begin
          arrived_q <= '0;
          state_q   <= BAR_COLLECT;
        end
      endcase
    end
  end

  // the release lasts exactly the one cycle spent in BAR_RELEASE
  assign barrier_events_o = (state_q == BAR_RELEASE) ? ctrl_if.bar_target : '0;

endmodule

`default_nettype wire

// ==== design/cluster_event_map.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "event_unit_macros.svh"

module cluster_event_map (
  // events produced inside the event unit
  input  event_unit_pkg::sw_evt_t   [`EU_NB_CORES-1:0] sw_events_i,
  input  event_unit_pkg::core_mask_t                   barrier_events_i,
  // events from the other cluster blocks
  input  logic [`EU_NB_CORES-1:0][3:0]                 acc_events_i,
  input  logic [`EU_NB_CORES-1:0][1:0]                 dma_events_i,
  input  logic [`EU_NB_CORES-1:0][1:0]                 timer_events_i,
  input  logic [`EU_NB_CORES-1:0][1:0]                 cluster_events_i,
  // shared sources that reach every core
  input  logic                                         mailbox_evt_i,
  input  logic                                         periph_fifo_event_i,
  output event_unit_pkg::evt_line_t [`EU_NB_CORES-1:0] events_mapped_o
);

  // every core gets the same bit layout, only the per-core sources differ
  for (genvar c = 0; c < `EU_NB_CORES; c++) begin : gen_core_map
    // unused positions stay zero
    assign events_mapped_o[c][31:28] = 4'h0;
    // the peripheral FIFO event is broadcast
    assign events_mapped_o[c][27]    = periph_fifo_event_i;
    assign events_mapped_o[c][26:25] = 2'b00;
    // the mailbox event is broadcast as well
    assign events_mapped_o[c][24]    = mailbox_evt_i;
    assign events_mapped_o[c][23:22] = cluster_events_i[c];
    // bits 18 and 17 would carry dispatch and mutex events, which this unit lacks
    assign events_mapped_o[c][21:17] = 5'b00000;
    // only cores in the barrier target see their release bit
    assign events_mapped_o[c][16]    = barrier_events_i[c];
    assign events_mapped_o[c][15:12] = acc_events_i[c];
    assign events_mapped_o[c][11:10] = timer_events_i[c];
    assign events_mapped_o[c][9:8]   = dma_events_i[c];
    // software events fill the low byte
    assign events_mapped_o[c][`EU_NB_SW_EVT-1:0] = sw_events_i[c];
  end

endmodule

`default_nettype wire

// ==== design/event_wb_slave.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "event_unit_macros.svh"

module event_wb_slave (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     wb_cyc_i,
  input  logic                     wb_stb_i,
  input  logic                     wb_we_i,
  input  event_unit_pkg::wb_addr_t wb_adr_i,
  input  event_unit_pkg::wb_data_t wb_dat_i,
  output event_unit_pkg::wb_data_t wb_dat_o,
  output logic                     wb_ack_o,
  event_ctrl_if.ctrl               ctrl_if
);
  import event_unit_pkg::*;

  localparam int core_idx_w = $clog2(`EU_NB_CORES);

  logic                         req;
  logic                         wr_en;
  logic [3:0]                   core_sel;
  logic [core_idx_w-1:0]        core_idx;
  logic                         core_hit;
  wb_addr_t                     reg_off;
  wb_data_t                     rdata;
  evt_line_t [`EU_NB_CORES-1:0] mask_q;
  core_mask_t                   bar_target_q;

  // a request counts once, the ack cycle itself is not a new request
  assign req   = wb_cyc_i & wb_stb_i & ~wb_ack_o;
  assign wr_en = req & wb_we_i;

  // the upper nibble picks the core window and the lower nibble the register
  assign core_sel = wb_adr_i[7:4];
  assign core_idx = wb_adr_i[4 +: core_idx_w];
  assign core_hit = int'(core_sel) < `EU_NB_CORES;
  assign reg_off  = {4'h0, wb_adr_i[3:0]};

  // register state seen by the rest of the unit
  assign ctrl_if.evt_mask   = mask_q;
  assign ctrl_if.bar_target = bar_target_q;

  // read mux, anything not decoded returns zero
  always_comb begin
    rdata = '0;
    if (core_hit) begin
      case (reg_off)
        `EU_REG_MASK:   rdata = mask_q[core_idx];
        `EU_REG_BUFFER: rdata = ctrl_if.evt_buffer[core_idx];
        `EU_REG_MASKED: rdata = ctrl_if.evt_buffer[core_idx] & mask_q[core_idx];
        default:        rdata = '0;
      endcase
    end else if (wb_adr_i == `EU_REG_BAR_TARGET) begin
      rdata[`EU_NB_CORES-1:0] = bar_target_q;
    end
  end

  // read data is captured with the request so it lines up with the ack
  always_ff @(posedge clk_i) begin
    if (req) begin
      wb_dat_o <= rdata;
    end
  end

  // ack, register writes and the strobes all land at the same edge
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wb_ack_o           <= 1'b0;
      mask_q             <= '0;
      bar_target_q       <= '0;
      ctrl_if.sw_evt     <= '0;
      ctrl_if.buf_clear  <= '0;
      ctrl_if.bar_arrive <= '0;
    end else begin
      wb_ack_o <= req;
      // strobes fall back to zero unless this cycle writes them
      ctrl_if.sw_evt     <= '0;
      ctrl_if.buf_clear  <= '0;
      ctrl_if.bar_arrive <= '0;
      if (wr_en) begin
        if (core_hit && (reg_off == `EU_REG_MASK)) begin
          mask_q[core_idx] <= wb_dat_i;
        end
        if (core_hit && (reg_off == `EU_REG_CLEAR)) begin
          ctrl_if.buf_clear[core_idx] <= wb_dat_i;
        end
        // the event byte goes to each core whose target bit is set
        if (wb_adr_i == `EU_REG_SW_TRIG) begin
          for (int c = 0; c < `EU_NB_CORES; c++) begin
            if (wb_dat_i[`EU_NB_SW_EVT + c]) begin
              ctrl_if.sw_evt[c] <= wb_dat_i[`EU_NB_SW_EVT-1:0];
            end
          end
        end
        if (wb_adr_i == `EU_REG_BAR_TARGET) begin
          bar_target_q <= wb_dat_i[`EU_NB_CORES-1:0];
        end
        if (wb_adr_i == `EU_REG_BAR_ARRIVE) begin
          ctrl_if.bar_arrive <= wb_dat_i[`EU_NB_CORES-1:0];
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/event_ctrl_if.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "event_unit_macros.svh"

interface event_ctrl_if;
  import event_unit_pkg::*;

  // register state and one-cycle strobes that leave the bus slave
  evt_line_t [`EU_NB_CORES-1:0] evt_mask;
  evt_line_t [`EU_NB_CORES-1:0] buf_clear;
  sw_evt_t   [`EU_NB_CORES-1:0] sw_evt;
  core_mask_t                   bar_target;
  core_mask_t                   bar_arrive;

  // buffer contents come back to the slave for register reads
  evt_line_t [`EU_NB_CORES-1:0] evt_buffer;

  // the bus slave owns all register state
  modport ctrl (
    output evt_mask, buf_clear, sw_evt, bar_target, bar_arrive,
    input  evt_buffer
  );

  // the barrier and the buffers consume the state and publish the buffers
  modport evt (
    input  evt_mask, buf_clear, sw_evt, bar_target, bar_arrive,
    output evt_buffer
  );

endinterface

`default_nettype wire

// ==== design/event_unit_pkg.sv ====
`default_nettype none

`include "event_unit_macros.svh"

package event_unit_pkg;

  // one bit per core, used for barrier target, arrivals and wake requests
  typedef logic [`EU_NB_CORES-1:0] core_mask_t;

  // the 32-bit event line of a single core
  typedef logic [31:0] evt_line_t;

  // software events aimed at one core
  typedef logic [`EU_NB_SW_EVT-1:0] sw_evt_t;

  // byte address seen on the register bus
  typedef logic [7:0] wb_addr_t;

  // register bus data word
  typedef logic [31:0] wb_data_t;

  // the barrier either collects arrivals or releases the waiting cores
  typedef enum logic {
    BAR_COLLECT,
    BAR_RELEASE
  } barrier_state_e;

endpackage

`default_nettype wire

// ==== design/event_unit_macros.svh ====
`ifndef EVENT_UNIT_MACROS_SVH
`define EVENT_UNIT_MACROS_SVH

// number of cores that get their own event line
`define EU_NB_CORES 4

// software events that can be raised towards each core
`define EU_NB_SW_EVT 8

// per-core registers sit in a 0x10 window, core n starts at n * 0x10
`define EU_REG_MASK   8'h00
`define EU_REG_BUFFER 8'h04
`define EU_REG_CLEAR  8'h08
`define EU_REG_MASKED 8'h0C

// global registers live above all per-core windows
`define EU_REG_SW_TRIG    8'h80
`define EU_REG_BAR_TARGET 8'h84
`define EU_REG_BAR_ARRIVE 8'h88

`endif
